//--- rtl/alut_pkg.sv
/*
 * Shared constants of the address lookup table: table geometry, entry field
 * positions, sweep command codes and AXI4-Lite register offsets.
 * Referenced by scoped names from the RTL and the testbench.
 */
package alut_pkg;

   // table geometry
   localparam int tbl_depth = 256;
   localparam int idx_w     = 8;        // low address bits index the table
   localparam int entry_w   = 83;

   // ----------------------------------------
   // entry layout {valid, time, port, addr}
   // ----------------------------------------
   localparam int f_valid   = 82;
   localparam int f_time_hi = 81;       // last accessed time
   localparam int f_time_lo = 50;
   localparam int f_port_hi = 49;
   localparam int f_port_lo = 48;
   localparam int f_addr_hi = 47;       // mac address down to bit 0

   // sweep commands, written to reg_cmd
   localparam logic [1:0] cmd_none       = 2'b00;
   localparam logic [1:0] cmd_inval_aged = 2'b10;
   localparam logic [1:0] cmd_inval_all  = 2'b11;

   // ----------------------------------------
   // axi byte offsets
   // ----------------------------------------
   localparam logic [7:0] reg_div    = 8'h00;  // time base divider
   localparam logic [7:0] reg_age    = 8'h04;  // best before age
   localparam logic [7:0] reg_cmd    = 8'h08;
   localparam logic [7:0] reg_status = 8'h0C;  // bit 1 inval in prog, bit 0 active
   localparam logic [7:0] reg_inv_lo = 8'h10;  // last invalidated addr 31:0
   localparam logic [7:0] reg_inv_hi = 8'h14;  // port in 17:16, addr 47:32 in 15:0

   // full count, for elapsed time across a wrap
   localparam logic [31:0] max_time = 32'hffff_ffff;

endpackage

//--- rtl/alut_mem.sv
/*
 * Table memory, 256 entries of 83 bits, one cycle registered read.
 * The age checker owns the port while it sweeps, the address checker
 * at all other times.
 */
`timescale 1ns/1ns

module alut_mem (
   input  logic                         pclk4,
   input  logic [alut_pkg::idx_w-1:0]   mem_addr,           // address checker port
   input  logic                         mem_write,
   input  logic [alut_pkg::entry_w-1:0] mem_write_data,
   input  logic [alut_pkg::idx_w-1:0]   mem_addr_age,       // age checker port
   input  logic                         mem_write_age,
   input  logic [alut_pkg::entry_w-1:0] mem_write_data_age,
   input  logic                         age_check_active,
   input  logic                         add_check_active,
   output logic [alut_pkg::entry_w-1:0] mem_read_data,
   output logic [alut_pkg::entry_w-1:0] mem_read_data_age
);

   logic [alut_pkg::entry_w-1:0] tbl [alut_pkg::tbl_depth];
   logic [alut_pkg::entry_w-1:0] rd_q;          // registered read word
   logic [alut_pkg::idx_w-1:0]   addr;
   logic [alut_pkg::entry_w-1:0] wdata;
   logic                         we;
   logic                         sel_age;

   // age checker wins only when no lookup is in flight
   assign sel_age = age_check_active && !add_check_active;
   assign addr    = sel_age ? mem_addr_age : mem_addr;
   assign we      = sel_age ? mem_write_age : mem_write;
   assign wdata   = sel_age ? mem_write_data_age : mem_write_data;

   always_ff @(posedge pclk4)
   begin
      if (we)
         tbl[addr] <= wdata;
      rd_q <= tbl[addr];                        // old word on a write, unused then
   end

   // both checkers see the same read word
   assign mem_read_data     = rd_q;
   assign mem_read_data_age = rd_q;

endmodule

//--- rtl/alut_age_checker.sv
/*
 * Age checker: local time base, in-date test for lookups, and the
 * invalidate-aged and invalidate-all table sweeps started by command.
 * Records the address and port of the last entry it cleared.
 */
`timescale 1ns/1ns

module alut_age_checker (
   input  logic                         pclk4,
   input  logic                         n_p_reset4,
   input  logic [1:0]                   command,            // one cycle pulse
   input  logic [7:0]                   div_clk,
   input  logic [alut_pkg::entry_w-1:0] mem_read_data_age,
   input  logic                         check_age,          // lookup age query
   input  logic [31:0]                  last_accessed,
   input  logic [31:0]                  best_bfr_age,
   input  logic                         add_check_active,
   output logic [31:0]                  curr_time,
   output logic [alut_pkg::idx_w-1:0]   mem_addr_age,
   output logic                         mem_write_age,
   output logic [alut_pkg::entry_w-1:0] mem_write_data_age,
   output logic [alut_pkg::f_addr_hi:0] lst_inv_addr,
   output logic [1:0]                   lst_inv_port,
   output logic                         age_confirmed,      // qualifies age_ok
   output logic                         age_ok,             // set means in date
   output logic                         inval_in_prog,
   output logic                         age_check_active
);

   typedef enum logic [2:0] {
      st_idle, st_aged_rd, st_aged_wr, st_inval_all, st_age_chk
   } state_t;

   localparam logic [alut_pkg::idx_w-1:0] last_idx = alut_pkg::idx_w'(alut_pkg::tbl_depth - 1);

   state_t      state;
   state_t      nxt_state;
   logic [7:0]  div_cnt;
   logic [1:0]  cmd_pend;           // command held while a lookup owns the table
   logic [1:0]  eff_cmd;
   logic        start;
   logic        last;
   logic [31:0] acc_time;           // lookup time, held from check_age
   logic [31:0] chk_time;
   logic [31:0] elapsed;

   // ----------------------------------------
   // time base
   // ----------------------------------------
   always_ff @(posedge pclk4 or negedge n_p_reset4)
   begin
      if (!n_p_reset4)
      begin
         div_cnt   <= '0;
         curr_time <= '0;
      end
      else if (div_cnt == div_clk)          // tick every div_clk+1 cycles
      begin
         div_cnt   <= '0;
         curr_time <= curr_time + 32'd1;
      end
      else
         div_cnt <= div_cnt + 8'd1;
   end

   // a fresh command wins over a held one
   assign eff_cmd = (command != alut_pkg::cmd_none) ? command : cmd_pend;
   assign start   = (eff_cmd == alut_pkg::cmd_inval_aged) || (eff_cmd == alut_pkg::cmd_inval_all);
   assign last    = (mem_addr_age == last_idx);

   // ----------------------------------------
   // sweep and age check fsm
   // ----------------------------------------
   always_comb
   begin
      nxt_state = state;
      case (state)
         st_idle:
            if (add_check_active)           // lookup first, sweep waits
            begin
               if (check_age)
                  nxt_state = st_age_chk;
            end
            else if (eff_cmd == alut_pkg::cmd_inval_aged)
               nxt_state = st_aged_rd;
            else if (eff_cmd == alut_pkg::cmd_inval_all)
               nxt_state = st_inval_all;
         st_aged_rd:
            nxt_state = st_age_chk;         // read word arrives next cycle
         st_age_chk:
            if (age_confirmed)
            begin
               if (!inval_in_prog)          // answer for the address checker
                  nxt_state = st_idle;
               else if (mem_read_data_age[alut_pkg::f_valid] && !age_ok)
                  nxt_state = st_aged_wr;
               else if (last)
                  nxt_state = st_idle;
               else
                  nxt_state = st_aged_rd;
            end
         st_aged_wr:
            nxt_state = last ? st_idle : st_aged_rd;
         st_inval_all:
            nxt_state = last ? st_idle : st_inval_all;
         default:
            nxt_state = st_idle;
      endcase
   end

   always_ff @(posedge pclk4 or negedge n_p_reset4)
   begin
      if (!n_p_reset4)
      begin
         state         <= st_idle;
         cmd_pend      <= alut_pkg::cmd_none;
         inval_in_prog <= 1'b0;
         mem_addr_age  <= '0;
      end
      else
      begin
         state <= nxt_state;
         if (state == st_idle && !add_check_active)
            cmd_pend <= alut_pkg::cmd_none; // served now or nothing held
         else if (command != alut_pkg::cmd_none)
            cmd_pend <= command;
         if (state == st_idle)
            inval_in_prog <= (nxt_state == st_aged_rd) || (nxt_state == st_inval_all);
         else if (nxt_state == st_idle)
            inval_in_prog <= 1'b0;
         if (state == st_idle)
            mem_addr_age <= '0;             // every sweep starts at index 0
         else if (state == st_inval_all || nxt_state == st_aged_rd)
            mem_addr_age <= mem_addr_age + 1'b1;
      end
   end

   assign mem_write_age      = (state == st_aged_wr) || (state == st_inval_all);
   assign mem_write_data_age = '0;          // clearing only
   assign age_check_active   = (state != st_idle) || start;

   // ----------------------------------------
   // in-date test, wrap of the time base allowed for
   // ----------------------------------------
   always_ff @(posedge pclk4)
   begin
      if (check_age)
         acc_time <= last_accessed;
   end

   assign chk_time = inval_in_prog ? mem_read_data_age[alut_pkg::f_time_hi:alut_pkg::f_time_lo]
                                   : acc_time;
   assign elapsed  = (curr_time >= chk_time) ? (curr_time - chk_time)
                                             : (curr_time + (alut_pkg::max_time - chk_time) + 32'd1);

   always_ff @(posedge pclk4 or negedge n_p_reset4)
   begin
      if (!n_p_reset4)
      begin
         age_confirmed <= 1'b0;
         age_ok        <= 1'b0;
         lst_inv_addr  <= '0;
         lst_inv_port  <= '0;
      end
      else
      begin
         age_confirmed <= (state == st_age_chk) && !age_confirmed;  // single pulse
         age_ok        <= best_bfr_age > elapsed;
         if (state == st_aged_wr)           // entry being cleared
         begin
            lst_inv_addr <= mem_read_data_age[alut_pkg::f_addr_hi:0];
            lst_inv_port <= mem_read_data_age[alut_pkg::f_port_hi:alut_pkg::f_port_lo];
         end
      end
   end

endmodule

//--- rtl/alut_addr_checker.sv
/*
 * Address checker: takes one lookup at a time, reads the destination entry,
 * asks the age checker whether it is in date, returns hit and port, then
 * learns the source address into its own entry.
 */
`timescale 1ns/1ns

module alut_addr_checker (
   input  logic                         pclk4,
   input  logic                         n_p_reset4,
   input  logic                         req_valid,
   input  logic [alut_pkg::f_addr_hi:0] req_dst,
   input  logic [alut_pkg::f_addr_hi:0] req_src,
   input  logic [1:0]                   req_port,       // ingress port
   input  logic [alut_pkg::entry_w-1:0] mem_read_data,
   input  logic [31:0]                  curr_time,
   input  logic                         age_confirmed,
   input  logic                         age_ok,
   input  logic                         age_check_active,
   output logic                         req_ready,
   output logic                         resp_valid,
   output logic                         resp_hit,
   output logic [1:0]                   resp_port,
   output logic [alut_pkg::idx_w-1:0]   mem_addr,
   output logic                         mem_write,
   output logic [alut_pkg::entry_w-1:0] mem_write_data,
   output logic                         check_age,
   output logic [31:0]                  last_accessed,
   output logic                         add_check_active
);

   typedef enum logic [1:0] {s_idle, s_rd, s_age, s_wait} state_t;

   state_t                       state;
   logic [alut_pkg::f_addr_hi:0] dst_q;     // request held while in flight
   logic [alut_pkg::f_addr_hi:0] src_q;
   logic [1:0]                   port_q;
   logic                         take;
   logic                         done;
   logic                         hit;

   // blocked during a lookup and during a sweep
   assign req_ready = (state == s_idle) && !(age_check_active && !add_check_active);
   assign take      = req_valid && req_ready;
   assign done      = (state == s_wait) && age_confirmed;

   always_ff @(posedge pclk4 or negedge n_p_reset4)
   begin
      if (!n_p_reset4)
         state <= s_idle;
      else
         case (state)
            s_idle:  if (take) state <= s_rd;
            s_rd:    state <= s_age;        // destination read in flight
            s_age:   state <= s_wait;       // query goes out
            s_wait:  if (age_confirmed) state <= s_idle;
            default: state <= s_idle;
         endcase
   end

   always_ff @(posedge pclk4)
   begin
      if (take)
      begin
         dst_q  <= req_dst;
         src_q  <= req_src;
         port_q <= req_port;
      end
   end

   assign add_check_active = (state != s_idle);
   assign check_age        = (state == s_age);
   assign last_accessed    = mem_read_data[alut_pkg::f_time_hi:alut_pkg::f_time_lo];

   // ----------------------------------------
   // destination decision and source learning
   // ----------------------------------------
   assign hit = mem_read_data[alut_pkg::f_valid] && age_ok
                && (mem_read_data[alut_pkg::f_addr_hi:0] == dst_q);

   // source write lands in the cycle of the age answer, table still ours
   assign mem_addr       = done ? src_q[alut_pkg::idx_w-1:0] : dst_q[alut_pkg::idx_w-1:0];
   assign mem_write      = done;
   assign mem_write_data = {1'b1, curr_time, port_q, src_q};

   always_ff @(posedge pclk4 or negedge n_p_reset4)
   begin
      if (!n_p_reset4)
         resp_valid <= 1'b0;
      else
         resp_valid <= done;                // one cycle pulse
   end

   always_ff @(posedge pclk4)
   begin
      if (done)
      begin
         resp_hit  <= hit;
         resp_port <= mem_read_data[alut_pkg::f_port_hi:alut_pkg::f_port_lo];
      end
   end

endmodule

//--- rtl/alut_regs.sv
/*
 * AXI4-Lite register block: divider and best before age configuration,
 * a write-only command that becomes a one cycle pulse, status and the
 * last invalidated record. Full word writes, one response outstanding.
 */
`timescale 1ns/1ns

module alut_regs (
   input  logic                         pclk4,
   input  logic                         n_p_reset4,
   input  logic                         aw_valid,
   output logic                         aw_ready,
   input  logic [7:0]                   aw_addr,
   input  logic                         w_valid,
   output logic                         w_ready,
   input  logic [31:0]                  w_data,
   output logic                         b_valid,
   input  logic                         b_ready,
   output logic [1:0]                   b_resp,
   input  logic                         ar_valid,
   output logic                         ar_ready,
   input  logic [7:0]                   ar_addr,
   output logic                         r_valid,
   input  logic                         r_ready,
   output logic [31:0]                  r_data,
   output logic [1:0]                   r_resp,
   output logic [7:0]                   div_clk,
   output logic [31:0]                  best_bfr_age,
   output logic [1:0]                   command,
   input  logic                         age_check_active,
   input  logic                         inval_in_prog,
   input  logic [alut_pkg::f_addr_hi:0] lst_inv_addr,
   input  logic [1:0]                   lst_inv_port
);

   logic wr_go;     // address and data taken together
   logic rd_go;

   assign aw_ready = !b_valid;
   assign w_ready  = !b_valid;
   assign ar_ready = !r_valid;
   assign wr_go    = aw_valid && w_valid && !b_valid;
   assign rd_go    = ar_valid && !r_valid;
   assign b_resp   = 2'b00;                 // always OKAY
   assign r_resp   = 2'b00;

   always_ff @(posedge pclk4 or negedge n_p_reset4)
   begin
      if (!n_p_reset4)
      begin
         div_clk      <= '0;
         best_bfr_age <= '0;
         command      <= alut_pkg::cmd_none;
         b_valid      <= 1'b0;
         r_valid      <= 1'b0;
      end
      else
      begin
         command <= alut_pkg::cmd_none;
         if (wr_go && aw_addr == alut_pkg::reg_div)
            div_clk <= w_data[7:0];
         if (wr_go && aw_addr == alut_pkg::reg_age)
            best_bfr_age <= w_data;
         if (wr_go && aw_addr == alut_pkg::reg_cmd)
            command <= w_data[1:0];         // pulse, next cycle back to none
         if (wr_go)
            b_valid <= 1'b1;
         else if (b_ready)
            b_valid <= 1'b0;
         if (rd_go)
            r_valid <= 1'b1;
         else if (r_ready)
            r_valid <= 1'b0;
      end
   end

   // read decode, unknown offsets and reg_cmd give zero
   always_ff @(posedge pclk4)
   begin
      if (rd_go)
         case (ar_addr)
            alut_pkg::reg_div:    r_data <= {24'd0, div_clk};
            alut_pkg::reg_age:    r_data <= best_bfr_age;
            alut_pkg::reg_status: r_data <= {30'd0, inval_in_prog, age_check_active};
            alut_pkg::reg_inv_lo: r_data <= lst_inv_addr[31:0];
            alut_pkg::reg_inv_hi: r_data <= {14'd0, lst_inv_port, lst_inv_addr[47:32]};
            default:              r_data <= '0;
         endcase
   end

endmodule

//--- rtl/alut_top.sv
/*
 * Address lookup table top level. The register block and the lookup port
 * bring in work, the table holds the entries, the two checkers update it.
 */
`timescale 1ns/1ns

module alut_top (
   input  logic                         pclk4,
   input  logic                         n_p_reset4,
   input  logic                         aw_valid,
   output logic                         aw_ready,
   input  logic [7:0]                   aw_addr,
   input  logic                         w_valid,
   output logic                         w_ready,
   input  logic [31:0]                  w_data,
   output logic                         b_valid,
   input  logic                         b_ready,
   output logic [1:0]                   b_resp,
   input  logic                         ar_valid,
   output logic                         ar_ready,
   input  logic [7:0]                   ar_addr,
   output logic                         r_valid,
   input  logic                         r_ready,
   output logic [31:0]                  r_data,
   output logic [1:0]                   r_resp,
   input  logic                         req_valid,
   output logic                         req_ready,
   input  logic [alut_pkg::f_addr_hi:0] req_dst,
   input  logic [alut_pkg::f_addr_hi:0] req_src,
   input  logic [1:0]                   req_port,
   output logic                         resp_valid,
   output logic                         resp_hit,
   output logic [1:0]                   resp_port
);

   // ----------------------------------------
   // configuration and status
   // ----------------------------------------
   logic [7:0]                   div_clk;
   logic [31:0]                  best_bfr_age;
   logic [1:0]                   command;
   logic                         age_check_active;
   logic                         inval_in_prog;
   logic [alut_pkg::f_addr_hi:0] lst_inv_addr;
   logic [1:0]                   lst_inv_port;

   // checker handshake
   logic                         check_age;
   logic [31:0]                  last_accessed;
   logic                         add_check_active;
   logic                         age_confirmed;
   logic                         age_ok;
   logic [31:0]                  curr_time;

   // table ports
   logic [alut_pkg::idx_w-1:0]   mem_addr;
   logic                         mem_write;
   logic [alut_pkg::entry_w-1:0] mem_write_data;
   logic [alut_pkg::entry_w-1:0] mem_read_data;
   logic [alut_pkg::idx_w-1:0]   mem_addr_age;
   logic                         mem_write_age;
   logic [alut_pkg::entry_w-1:0] mem_write_data_age;
   logic [alut_pkg::entry_w-1:0] mem_read_data_age;

   alut_regs u_regs (
      .pclk4, .n_p_reset4,
      .aw_valid, .aw_ready, .aw_addr, .w_valid, .w_ready, .w_data,
      .b_valid, .b_ready, .b_resp,
      .ar_valid, .ar_ready, .ar_addr, .r_valid, .r_ready, .r_data, .r_resp,
      .div_clk, .best_bfr_age, .command,
      .age_check_active, .inval_in_prog, .lst_inv_addr, .lst_inv_port
   );

   alut_age_checker u_age_checker (
      .pclk4, .n_p_reset4, .command, .div_clk, .mem_read_data_age,
      .check_age, .last_accessed, .best_bfr_age, .add_check_active,
      .curr_time, .mem_addr_age, .mem_write_age, .mem_write_data_age,
      .lst_inv_addr, .lst_inv_port, .age_confirmed, .age_ok,
      .inval_in_prog, .age_check_active
   );

   alut_addr_checker u_addr_checker (
      .pclk4, .n_p_reset4, .req_valid, .req_dst, .req_src, .req_port,
      .mem_read_data, .curr_time, .age_confirmed, .age_ok, .age_check_active,
      .req_ready, .resp_valid, .resp_hit, .resp_port,
      .mem_addr, .mem_write, .mem_write_data,
      .check_age, .last_accessed, .add_check_active
   );

   alut_mem u_mem (
      .pclk4,
      .mem_addr, .mem_write, .mem_write_data,
      .mem_addr_age, .mem_write_age, .mem_write_data_age,
      .age_check_active, .add_check_active,
      .mem_read_data, .mem_read_data_age
   );

endmodule

//--- tests/alut_assertions.sv
/*
 * Concurrent checks on the age checker, bound into every instance.
 * fail_cnt counts the checks that fired.
 */
`timescale 1ns/1ns

module alut_assertions (
   input logic                         pclk4,
   input logic                         n_p_reset4,
   input logic [alut_pkg::entry_w-1:0] mem_write_data_age,
   input logic                         age_confirmed,
   input logic                         inval_in_prog,
   input logic                         age_check_active
);

   int fail_cnt = 0;

   // the age checker only ever clears entries
   clear_only: assert property (@(posedge pclk4) disable iff (!n_p_reset4)
      mem_write_data_age == '0)
   else
   begin
      fail_cnt++;
      $error("age checker wrote a non-zero entry");
   end

   // answer to an age query is a single pulse
   confirm_pulse: assert property (@(posedge pclk4) disable iff (!n_p_reset4)
      age_confirmed |=> !age_confirmed)
   else
   begin
      fail_cnt++;
      $error("age_confirmed high for two cycles");
   end

   sweep_active: assert property (@(posedge pclk4) disable iff (!n_p_reset4)
      inval_in_prog |-> age_check_active)
   else
   begin
      fail_cnt++;
      $error("inval_in_prog without age_check_active");
   end

endmodule

bind alut_age_checker alut_assertions u_assertions (
   .pclk4,
   .n_p_reset4,
   .mem_write_data_age,
   .age_confirmed,
   .inval_in_prog,
   .age_check_active
);

//--- tests/alut_tb.sv
/*
 * Testbench for the address lookup table. Replays tests/alut_trace.txt
 * one operation per line: AXI4-Lite register writes and reads, lookups,
 * and waits for the end of a table sweep. Run from the project root.
 */
`timescale 1ns/1ns

module alut_tb;

   logic        pclk4;
   logic        n_p_reset4;
   // axi4-lite side
   logic        aw_valid;
   logic        aw_ready;
   logic [7:0]  aw_addr;
   logic        w_valid;
   logic        w_ready;
   logic [31:0] w_data;
   logic        b_valid;
   logic        b_ready;
   logic [1:0]  b_resp;
   logic        ar_valid;
   logic        ar_ready;
   logic [7:0]  ar_addr;
   logic        r_valid;
   logic        r_ready;
   logic [31:0] r_data;
   logic [1:0]  r_resp;
   // lookup port
   logic        req_valid;
   logic        req_ready;
   logic [47:0] req_dst;
   logic [47:0] req_src;
   logic [1:0]  req_port;
   logic        resp_valid;
   logic        resp_hit;
   logic [1:0]  resp_port;

   // trace contents with one entry per operation
   logic [7:0]  op_q [$];
   logic [47:0] a1_q [$];
   logic [47:0] a2_q [$];
   logic [47:0] a3_q [$];
   logic [47:0] exp_q [$];
   bit          trace_loaded;

   alut_top uut (.*);

   initial
   begin
      pclk4 = 1'b0;
      forever #2 pclk4 = ~pclk4;    // 4 ns period
   end

   task automatic end_in_failure();
      $display("test failed");
      $fatal(1);
   endtask

   task automatic expect_equal(input logic [47:0] actual, input logic [47:0] expected,
                               input string what);
      if (actual !== expected)
      begin
         $display("Fail at %0t ns: %s, got 0x%0h, expected 0x%0h",
                  $time, what, actual, expected);
         end_in_failure();
      end
   endtask

   // ----------------------------------------
   // trace reader
   // ----------------------------------------
   task automatic load_trace();
      integer             fd;
      integer             n;
      logic [63:0]        tok;
      logic [8*160-1:0]   rest;
      logic [47:0]        f1;
      logic [47:0]        f2;
      logic [47:0]        f3;
      logic [47:0]        fe;
      fd = $fopen("tests/alut_trace.txt", "r");
      if (fd == 0)
      begin
         $display("cannot open the trace file tests/alut_trace.txt");
         end_in_failure();
      end
      n = $fscanf(fd, "%s", tok);
      while (n == 1)
      begin
         if (tok[7:0] == "#")
            n = $fgets(rest, fd);           // skip comment line
         else
         begin
            n = $fscanf(fd, "%h %h %h %h", f1, f2, f3, fe);
            if (n != 4)
            begin
               $display("trace line %0d is malformed", op_q.size() + 1);
               end_in_failure();
            end
            op_q.push_back(tok[7:0]);
            a1_q.push_back(f1);
            a2_q.push_back(f2);
            a3_q.push_back(f3);
            exp_q.push_back(fe);
         end
         n = $fscanf(fd, "%s", tok);
      end
      $fclose(fd);
   endtask

   // ----------------------------------------
   // bus drivers start and end 1 ns after a rising edge
   // ----------------------------------------
   task automatic write_reg(input logic [7:0] addr, input logic [31:0] data,
                            output logic [1:0] resp);
      aw_addr  = addr;
      w_data   = data;
      aw_valid = 1'b1;
      w_valid  = 1'b1;
      @(negedge pclk4);
      while (!(aw_ready && w_ready))
         @(negedge pclk4);
      @(posedge pclk4);                   // address and data taken together
      #1;
      aw_valid = 1'b0;
      w_valid  = 1'b0;
      b_ready  = 1'b1;
      @(negedge pclk4);
      while (!b_valid)
         @(negedge pclk4);
      resp = b_resp;
      @(posedge pclk4);
      #1;
      b_ready = 1'b0;
   endtask

   task automatic read_reg(input logic [7:0] addr, output logic [31:0] data,
                           output logic [1:0] resp);
      ar_addr  = addr;
      ar_valid = 1'b1;
      @(negedge pclk4);
      while (!ar_ready)
         @(negedge pclk4);
      @(posedge pclk4);
      #1;
      ar_valid = 1'b0;
      r_ready  = 1'b1;
      @(negedge pclk4);
      while (!r_valid)
         @(negedge pclk4);
      data = r_data;                      // sampled mid cycle
      resp = r_resp;
      @(posedge pclk4);
      #1;
      r_ready = 1'b0;
   endtask

   task automatic run_lookup(input logic [47:0] dst, input logic [47:0] src,
                             input logic [1:0] port, output logic hit,
                             output logic [1:0] rport);
      req_dst   = dst;
      req_src   = src;
      req_port  = port;
      req_valid = 1'b1;
      @(negedge pclk4);
      while (!req_ready)                  // low during a sweep
         @(negedge pclk4);
      @(posedge pclk4);
      #1;
      req_valid = 1'b0;
      @(negedge pclk4);
      while (!resp_valid)                 // one cycle pulse
         @(negedge pclk4);
      hit   = resp_hit;
      rport = resp_port;
      @(posedge pclk4);
      #1;
   endtask

   // poll status until neither active nor invalidating
   task automatic wait_idle();
      logic [31:0] status;
      logic [1:0]  resp;
      read_reg(alut_pkg::reg_status, status, resp);
      expect_equal({46'd0, resp}, 48'd0, "status poll r_resp");
      while (status[1:0] != 2'b00)
      begin
         read_reg(alut_pkg::reg_status, status, resp);
         expect_equal({46'd0, resp}, 48'd0, "status poll r_resp");
      end
   endtask

   // 200 cycles for each trace line
   initial
   begin
      wait (trace_loaded);
      repeat (op_q.size() * 200) @(posedge pclk4);
      $display("the run timed out after %0d cycles", op_q.size() * 200);
      end_in_failure();
   end

   // a fired assertion in the bound checker ends the run
   initial
   begin
      wait (uut.u_age_checker.u_assertions.fail_cnt != 0);
      $display("an assertion in the age checker failed");
      end_in_failure();
   end

   initial
   begin
      logic [31:0] rdata;
      logic [1:0]  rresp;
      logic [1:0]  bresp;
      logic        hit;
      logic [1:0]  rport;
      string       what;
      n_p_reset4 = 1'b0;
      aw_valid   = 1'b0;
      aw_addr    = '0;
      w_valid    = 1'b0;
      w_data     = '0;
      b_ready    = 1'b0;
      ar_valid   = 1'b0;
      ar_addr    = '0;
      r_ready    = 1'b0;
      req_valid  = 1'b0;
      req_dst    = '0;
      req_src    = '0;
      req_port   = '0;
      load_trace();
      trace_loaded = 1'b1;
      repeat (10) @(posedge pclk4);
      #1;
      n_p_reset4 = 1'b1;
      foreach (op_q[i])
      begin
         what = $sformatf("op %0d %s 0x%0h", i, op_q[i], a1_q[i]);
         case (op_q[i])
            "W":
            begin
               write_reg(a1_q[i][7:0], a2_q[i][31:0], bresp);
               expect_equal({46'd0, bresp}, exp_q[i], what);
            end
            "R":
            begin
               read_reg(a1_q[i][7:0], rdata, rresp);
               expect_equal({16'd0, rdata}, exp_q[i], what);
               expect_equal({46'd0, rresp}, 48'd0, {what, " r_resp"});
            end
            "L":
            begin
               run_lookup(a1_q[i], a2_q[i], a3_q[i][1:0], hit, rport);
               if (exp_q[i][2])            // on a hit the port must match too
                  expect_equal({45'd0, hit, rport}, exp_q[i], what);
               else
                  expect_equal({47'd0, hit}, 48'd0, what);
            end
            "C":
               wait_idle();
            default:
            begin
               $display("unknown opcode %s at trace op %0d", op_q[i], i);
               end_in_failure();
            end
         endcase
      end
      if (uut.u_age_checker.u_assertions.fail_cnt == 0)
      begin
         $display("test passed");
         $finish;
      end
      else
         end_in_failure();
   end

endmodule

//--- tests/alut_trace.txt
# op a1 a2 a3 exp in hex; W offset data 0 bresp, R offset 0 0 rdata, C wait for idle
# L dst src port exp, where exp is 0 for a miss and 4+port for a hit
R 0c 0 0 0
R 10 0 0 0
R 14 0 0 0
W 00 3 0 0
R 00 0 0 3
W 04 ffff 0 0
R 04 0 0 ffff
W 08 3 0 0
C 0 0 0 0
L 0a0b0c0d0e40 0a0b0c0d0e05 2 0
L 0a0b0c0d0e05 0a0b0c0d0e40 1 6
L 0a0b0c0d0e77 0a0b0c0d0e05 2 0
L 0a0b0c0d0e40 0a0b0c0d0e05 2 5
W 04 0 0 0
L 0a0b0c0d0e05 0a0b0c0d0e40 1 0
W 08 2 0 0
R 0c 0 0 3
C 0 0 0 0
R 10 0 0 0c0d0e40
R 14 0 0 10a0b
W 04 ffff 0 0
L 0a0b0c0d0e05 0a0b0c0d0e10 3 0
L 0a0b0c0d0e40 0a0b0c0d0e10 3 0
W 08 3 0 0
C 0 0 0 0
L 0a0b0c0d0e10 0a0b0c0d0e20 0 0
L 0a0b0c0d0e20 0a0b0c0d0e20 0 4

//--- list.f
rtl/alut_pkg.sv
rtl/alut_mem.sv
rtl/alut_age_checker.sv
rtl/alut_addr_checker.sv
rtl/alut_regs.sv
rtl/alut_top.sv
tests/alut_assertions.sv
tests/alut_tb.sv

//--- Makefile
# Verilator lint and simulation of the address lookup table testbench
TOOL     = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = alut_tb
FILELIST = list.f
LOG      = sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(TOOL) --lint-only --timing -Wall --top-module $(TOP) -f $(FILELIST)

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "test passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
